// File: bench/tb_clock.sv
// Free-running testbench clock with period 4 that starts low and never stops on its own
module tb_clock (
  output logic clk_o
);

  // Half period of 2 time units
  initial begin
    clk_o = 1'b0;
    forever begin
      #2 clk_o = ~clk_o;
    end
  end

endmodule

// File: bench/vector_fus_stage_assert.sv
// Handshake checks bound into the stage, assuming the register file holds gnt low until it takes a write
module vector_fus_stage_assert (
  input logic                 clk_i,
  input logic                 rst_i,
  input logic                 alu_ready_o,
  input ara_pkg::vinsn_mask_t alu_vinsn_done_o,
  input logic                 alu_operand_ready_o [2],
  input logic                 alu_result_req_o,
  input ara_pkg::vid_t        alu_result_id_o,
  input ara_pkg::vaddr_t      alu_result_addr_o,
  input ara_pkg::elen_t       alu_result_wdata_o,
  input ara_pkg::strb_t       alu_result_be_o,
  input logic                 alu_result_gnt_i,
  input logic                 mfpu_ready_o,
  input ara_pkg::vinsn_mask_t mfpu_vinsn_done_o,
  input logic                 mfpu_operand_ready_o [3],
  input logic                 mfpu_result_req_o,
  input ara_pkg::vid_t        mfpu_result_id_o,
  input ara_pkg::vaddr_t      mfpu_result_addr_o,
  input ara_pkg::elen_t       mfpu_result_wdata_o,
  input ara_pkg::strb_t       mfpu_result_be_o,
  input logic                 mfpu_result_gnt_i
);

  // Failures seen so far, read back by the testbench at the end
  int unsigned fail_cnt = 0;

  // Write held until granted, payload frozen
  alu_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    alu_result_req_o && !alu_result_gnt_i |=> alu_result_req_o &&
    $stable({alu_result_id_o, alu_result_addr_o, alu_result_wdata_o, alu_result_be_o}))
  else begin
    $error("alu write dropped or changed before its grant");
    fail_cnt++;
  end

  mfpu_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    mfpu_result_req_o && !mfpu_result_gnt_i |=> mfpu_result_req_o &&
    $stable({mfpu_result_id_o, mfpu_result_addr_o, mfpu_result_wdata_o, mfpu_result_be_o}))
  else begin
    $error("mfpu write dropped or changed before its grant");
    fail_cnt++;
  end

  // At most one id finishes per unit and cycle
  done_onehot_a: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0(alu_vinsn_done_o) && $onehot0(mfpu_vinsn_done_o))
  else begin
    $error("done vector has more than one bit set");
    fail_cnt++;
  end

  // An idle unit takes no operands
  idle_alu_a: assert property (@(posedge clk_i) disable iff (rst_i)
    alu_ready_o |-> !alu_operand_ready_o[0] && !alu_operand_ready_o[1])
  else begin
    $error("alu took operands while idle");
    fail_cnt++;
  end

  idle_mfpu_a: assert property (@(posedge clk_i) disable iff (rst_i)
    mfpu_ready_o |-> !mfpu_operand_ready_o[0] && !mfpu_operand_ready_o[1] &&
    !mfpu_operand_ready_o[2])
  else begin
    $error("mfpu took operands while idle");
    fail_cnt++;
  end

endmodule

// File: bench/vector_fus_stage_tb.sv
// Random testbench for the lane execution stage, masked instructions run on one unit at a time
module vector_fus_stage_tb;
  import ara_pkg::*;

  localparam int ISSUE_TIMEOUT = 64;
  localparam int DONE_TIMEOUT  = 600;

  logic clk;
  logic rst;

  // Sequencer side
  vfu_op_e     vfu_op;
  vid_t        vfu_id;
  vlen_t       vfu_vl;
  vaddr_t      vfu_vd;
  logic        vfu_vm;
  logic        vfu_valid;
  logic        alu_ready;
  logic        mfpu_ready;
  vinsn_mask_t alu_done;
  vinsn_mask_t mfpu_done;

  // Operand queues
  elen_t alu_operand [2];
  logic  alu_valid [2];
  logic  alu_opnd_ready [2];
  elen_t mfpu_operand [3];
  logic  mfpu_valid [3];
  logic  mfpu_opnd_ready [3];

  // Write ports and mask stream
  logic   alu_req;
  vid_t   alu_wid;
  vaddr_t alu_waddr;
  elen_t  alu_wdata;
  strb_t  alu_be;
  logic   alu_gnt;
  logic   mfpu_req;
  vid_t   mfpu_wid;
  vaddr_t mfpu_waddr;
  elen_t  mfpu_wdata;
  strb_t  mfpu_be;
  logic   mfpu_gnt;
  strb_t  mask;
  logic   mask_valid;
  logic   mask_ready;

  // Random state and per-test stimulus mode
  logic [31:0] lfsr;
  logic        gnt_rand;
  logic        valid_rand;

  // Model, index 0 is the ALU and 1 the MFPU
  vfu_op_e     op_m [2];
  vid_t        id_m [2];
  vlen_t       vl_m [2];
  vaddr_t      vd_m [2];
  logic        vm_m [2];
  logic        busy_m [2];
  int          issued_m [2];
  int          written_m [2];
  int          last_wr_cyc [2];
  // Expected writes packed as id, addr, be, data
  logic [81:0] alu_exp_q [$];
  logic [81:0] mfpu_exp_q [$];
  int          cyc;

  string test_name;
  int    errors;
  int    test_err_base;
  int    tests_run;
  int    tests_failed;

  tb_clock u_clock (
    .clk_o (clk)
  );

  vector_fus_stage u_vector_fus_stage (
    .clk_i                 (clk),
    .rst_i                 (rst),
    .vfu_op_i              (vfu_op),
    .vfu_id_i              (vfu_id),
    .vfu_vl_i              (vfu_vl),
    .vfu_vd_i              (vfu_vd),
    .vfu_vm_i              (vfu_vm),
    .vfu_operation_valid_i (vfu_valid),
    .alu_ready_o           (alu_ready),
    .alu_vinsn_done_o      (alu_done),
    .mfpu_ready_o          (mfpu_ready),
    .mfpu_vinsn_done_o     (mfpu_done),
    .alu_operand_i         (alu_operand),
    .alu_operand_valid_i   (alu_valid),
    .alu_operand_ready_o   (alu_opnd_ready),
    .mfpu_operand_i        (mfpu_operand),
    .mfpu_operand_valid_i  (mfpu_valid),
    .mfpu_operand_ready_o  (mfpu_opnd_ready),
    .alu_result_req_o      (alu_req),
    .alu_result_id_o       (alu_wid),
    .alu_result_addr_o     (alu_waddr),
    .alu_result_wdata_o    (alu_wdata),
    .alu_result_be_o       (alu_be),
    .alu_result_gnt_i      (alu_gnt),
    .mfpu_result_req_o     (mfpu_req),
    .mfpu_result_id_o      (mfpu_wid),
    .mfpu_result_addr_o    (mfpu_waddr),
    .mfpu_result_wdata_o   (mfpu_wdata),
    .mfpu_result_be_o      (mfpu_be),
    .mfpu_result_gnt_i     (mfpu_gnt),
    .mask_i                (mask),
    .mask_valid_i          (mask_valid),
    .mask_ready_o          (mask_ready)
  );

  bind vector_fus_stage vector_fus_stage_assert u_assert (.*);

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[62:0], fb};
    end
    return v;
  endfunction

  function automatic logic is_mul_op(input vfu_op_e op);
    return (op == VMUL) || (op == VMACC);
  endfunction

  // Five ALU ops from three bits, upper codes folded back
  function automatic vfu_op_e pick_alu_op();
    logic [63:0] r;
    r = rand_bits(3);
    if (r > 64'd4) begin
      r = r - 64'd3;
    end
    return vfu_op_e'(r[2:0]);
  endfunction

  function automatic vfu_op_e pick_mul_op();
    return (|rand_bits(1)) ? VMACC : VMUL;
  endfunction

  // Reference arithmetic, low 64 bits kept
  function automatic elen_t model_result(input vfu_op_e op, input elen_t a, input elen_t b,
                                         input elen_t c);
    case (op)
      VADD:    return a + b;
      VSUB:    return a - b;
      VAND:    return a & b;
      VOR:     return a | b;
      VXOR:    return a ^ b;
      VMUL:    return a * b;
      default: return a * b + c;
    endcase
  endfunction

  // Next cycle, inputs change 1 unit after the edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
    for (int i = 0; i < 2; i++) begin
      alu_operand[i] = rand_bits(64);
      alu_valid[i]   = valid_rand ? |rand_bits(2) : 1'b1;
    end
    for (int i = 0; i < 3; i++) begin
      mfpu_operand[i] = rand_bits(64);
      mfpu_valid[i]   = valid_rand ? |rand_bits(2) : 1'b1;
    end
    mask       = strb_t'(rand_bits(8));
    mask_valid = valid_rand ? |rand_bits(2) : 1'b1;
    alu_gnt    = gnt_rand ? |rand_bits(1) : 1'b1;
    mfpu_gnt   = gnt_rand ? |rand_bits(1) : 1'b1;
  endtask

  task automatic expect_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: %s expected %b actual %b", test_name, what, exp, act);
    end
  endtask

  // Accepted instruction, fields as driven this cycle
  task automatic start_insn(input int u);
    if (busy_m[u]) begin
      errors++;
      $display("%s: %s accepted an instruction while busy", test_name,
               u == 0 ? "alu" : "mfpu");
    end
    op_m[u]      = vfu_op;
    id_m[u]      = vfu_id;
    vl_m[u]      = vfu_vl;
    vd_m[u]      = vfu_vd;
    vm_m[u]      = vfu_vm;
    busy_m[u]    = 1'b1;
    issued_m[u]  = 0;
    written_m[u] = 0;
  endtask

  // Expected write from the operands taken this cycle
  task automatic push_expected(input int u);
    elen_t  a;
    elen_t  b;
    elen_t  c;
    vaddr_t addr;
    strb_t  be;
    if (u == 0) begin
      a = alu_operand[0];
      b = alu_operand[1];
      c = '0;
    end else begin
      a = mfpu_operand[0];
      b = mfpu_operand[1];
      c = mfpu_operand[2];
    end
    addr = vd_m[u] + vaddr_t'(issued_m[u]);
    be   = vm_m[u] ? 8'hff : mask;
    if (!busy_m[u] || issued_m[u] >= int'(vl_m[u])) begin
      errors++;
      $display("%s: %s took an operand beyond its instruction", test_name,
               u == 0 ? "alu" : "mfpu");
    end
    issued_m[u] = issued_m[u] + 1;
    if (u == 0) begin
      alu_exp_q.push_back({id_m[u], addr, be, model_result(op_m[u], a, b, c)});
    end else begin
      mfpu_exp_q.push_back({id_m[u], addr, be, model_result(op_m[u], a, b, c)});
    end
  endtask

  task automatic check_write(input int u, input logic [81:0] act);
    logic [81:0] exp;
    if ((u == 0 && alu_exp_q.size() == 0) || (u == 1 && mfpu_exp_q.size() == 0)) begin
      errors++;
      $display("%s: %s wrote with no element pending", test_name, u == 0 ? "alu" : "mfpu");
    end else begin
      exp = (u == 0) ? alu_exp_q.pop_front() : mfpu_exp_q.pop_front();
      if (act !== exp) begin
        errors++;
        $display("ERROR %s: %s write expected %h actual %h", test_name,
                 u == 0 ? "alu" : "mfpu", exp, act);
      end
    end
    written_m[u]   = written_m[u] + 1;
    last_wr_cyc[u] = cyc;
  endtask

  task automatic check_done(input int u, input vinsn_mask_t done);
    vinsn_mask_t exp;
    exp = vinsn_mask_t'(1) << id_m[u];
    if (!busy_m[u]) begin
      errors++;
      $display("%s: %s pulsed done with no instruction running", test_name,
               u == 0 ? "alu" : "mfpu");
    end else begin
      if (done !== exp) begin
        errors++;
        $display("ERROR %s: done expected %b actual %b", test_name, exp, done);
      end
      if (written_m[u] != int'(vl_m[u])) begin
        errors++;
        $display("ERROR %s: writes before done expected %0d actual %0d", test_name,
                 vl_m[u], written_m[u]);
      end
      // Done one cycle after the last grant, unit free again
      if (cyc != last_wr_cyc[u] + 1 || !(u == 0 ? alu_ready : mfpu_ready)) begin
        errors++;
        $display("%s: done pulse or ready not in the cycle after the last grant", test_name);
      end
      busy_m[u] = 1'b0;
    end
  endtask

  // Each unit is free exactly while the model has nothing running on it
  task automatic check_unit_ready();
    expect_bit("alu_ready_o", !busy_m[0], alu_ready);
    expect_bit("mfpu_ready_o", !busy_m[1], mfpu_ready);
  endtask

  // Port readies against the running ops and the valids presented
  task automatic check_ready_ports();
    expect_bit("alu port 1 ready", alu_opnd_ready[0], alu_opnd_ready[1]);
    expect_bit("mfpu port 1 ready", mfpu_opnd_ready[0], mfpu_opnd_ready[1]);
    expect_bit("mfpu port 2 ready", mfpu_opnd_ready[0] && op_m[1] == VMACC,
               mfpu_opnd_ready[2]);
    expect_bit("mask ready", (alu_opnd_ready[0] && !vm_m[0]) ||
               (mfpu_opnd_ready[0] && !vm_m[1]), mask_ready);
    if (alu_opnd_ready[0] && !(alu_valid[0] && alu_valid[1] && (vm_m[0] || mask_valid))) begin
      errors++;
      $display("%s: alu took an element while an operand or the mask was not valid",
               test_name);
    end
    if (mfpu_opnd_ready[0] && !(mfpu_valid[0] && mfpu_valid[1] &&
        (op_m[1] != VMACC || mfpu_valid[2]) && (vm_m[1] || mask_valid))) begin
      errors++;
      $display("%s: mfpu took an element while an operand or the mask was not valid",
               test_name);
    end
  endtask

  // Model and checker, sampled mid cycle where inputs and outputs are settled
  always @(negedge clk) begin
    cyc = cyc + 1;
    if (!rst) begin
      // Done first, a new accept may follow in the same cycle
      if (alu_done != '0) check_done(0, alu_done);
      if (mfpu_done != '0) check_done(1, mfpu_done);
      if (alu_req && alu_gnt) check_write(0, {alu_wid, alu_waddr, alu_be, alu_wdata});
      if (mfpu_req && mfpu_gnt) check_write(1, {mfpu_wid, mfpu_waddr, mfpu_be, mfpu_wdata});
      check_unit_ready();
      if (vfu_valid && alu_ready && !is_mul_op(vfu_op)) start_insn(0);
      if (vfu_valid && mfpu_ready && is_mul_op(vfu_op)) start_insn(1);
      check_ready_ports();
      if (alu_opnd_ready[0]) push_expected(0);
      if (mfpu_opnd_ready[0]) push_expected(1);
    end
  end

  // Hold the instruction until the owning unit is ready
  task automatic issue_insn(input vfu_op_e op, input logic vm);
    int   wait_cnt;
    logic taken;
    vfu_op    = op;
    vfu_id    = vid_t'(rand_bits(2));
    vfu_vl    = vlen_t'(rand_bits(4)) + 8'd1;
    vfu_vd    = vaddr_t'(rand_bits(8));
    vfu_vm    = vm;
    vfu_valid = 1'b1;
    wait_cnt  = 0;
    taken     = 1'b0;
    while (!taken && wait_cnt < ISSUE_TIMEOUT) begin
      taken = is_mul_op(op) ? mfpu_ready : alu_ready;
      next_cycle();
      wait_cnt++;
    end
    vfu_valid = 1'b0;
    if (!taken) begin
      errors++;
      $display("%s: timeout, no unit accepted the instruction", test_name);
    end
  endtask

  task automatic wait_done(input int u);
    int wait_cnt;
    wait_cnt = 0;
    while (busy_m[u] && wait_cnt < DONE_TIMEOUT) begin
      next_cycle();
      wait_cnt++;
    end
    if (busy_m[u]) begin
      errors++;
      $display("%s: timeout, %s never signalled done", test_name, u == 0 ? "alu" : "mfpu");
    end
  endtask

  task automatic run_one(input vfu_op_e op, input logic vm);
    issue_insn(op, vm);
    wait_done(is_mul_op(op) ? 1 : 0);
  endtask

  task automatic begin_test(input string name, input logic rand_gnt, input logic rand_valid);
    test_name     = name;
    test_err_base = errors;
    gnt_rand      = rand_gnt;
    valid_rand    = rand_valid;
  endtask

  task automatic end_test();
    if (alu_exp_q.size() != 0 || mfpu_exp_q.size() != 0) begin
      errors++;
      $display("%s: expected writes never appeared", test_name);
    end
    tests_run++;
    if (errors != test_err_base) tests_failed++;
    $display("%s %s, %0d errors", test_name,
             errors == test_err_base ? "passed" : "failed", errors - test_err_base);
  endtask

  initial begin
    vfu_op     = VADD;
    vfu_id     = '0;
    vfu_vl     = 8'd1;
    vfu_vd     = '0;
    vfu_vm     = 1'b1;
    vfu_valid  = 1'b0;
    for (int i = 0; i < 2; i++) begin
      alu_operand[i] = '0;
      alu_valid[i]   = 1'b0;
      op_m[i]        = VADD;
      vm_m[i]        = 1'b1;
      busy_m[i]      = 1'b0;
      last_wr_cyc[i] = 0;
    end
    for (int i = 0; i < 3; i++) begin
      mfpu_operand[i] = '0;
      mfpu_valid[i]   = 1'b0;
    end
    alu_gnt      = 1'b0;
    mfpu_gnt     = 1'b0;
    mask         = '0;
    mask_valid   = 1'b0;
    lfsr         = 32'h2ca37b91;
    cyc          = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    rst          = 1'b1;
    begin_test("reset_state", 1'b0, 1'b0);
    repeat (8) next_cycle();
    rst = 1'b0;
    next_cycle();
    expect_bit("alu_ready_o", 1'b1, alu_ready);
    expect_bit("mfpu_ready_o", 1'b1, mfpu_ready);
    expect_bit("result req", 1'b0, alu_req | mfpu_req);
    expect_bit("done", 1'b0, |{alu_done, mfpu_done});
    expect_bit("operand ready", 1'b0, alu_opnd_ready[0] | alu_opnd_ready[1] |
               mfpu_opnd_ready[0] | mfpu_opnd_ready[1] | mfpu_opnd_ready[2]);
    expect_bit("mask_ready_o", 1'b0, mask_ready);
    end_test();

    begin_test("alu_ops", 1'b0, 1'b0);
    repeat (8) run_one(pick_alu_op(), 1'b1);
    end_test();

    begin_test("mul_ops", 1'b0, 1'b0);
    repeat (8) run_one(pick_mul_op(), 1'b1);
    end_test();

    // Masks on one unit at a time
    begin_test("masking", 1'b0, 1'b1);
    repeat (4) begin
      run_one(pick_alu_op(), 1'b0);
      run_one(pick_mul_op(), 1'b0);
    end
    end_test();

    begin_test("back_pressure", 1'b1, 1'b1);
    repeat (12) begin
      run_one((|rand_bits(1)) ? pick_mul_op() : pick_alu_op(), ~|rand_bits(2));
    end
    end_test();

    // Only the ALU may run masked while both are busy
    begin_test("concurrency", 1'b1, 1'b1);
    repeat (6) begin
      issue_insn(pick_alu_op(), |rand_bits(1));
      issue_insn(pick_mul_op(), 1'b1);
      wait_done(0);
      wait_done(1);
    end
    end_test();

    errors = errors + int'(u_vector_fus_stage.u_assert.fail_cnt);
    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+source
source/ara_pkg.sv
source/valu.sv
source/vmfpu.sv
source/vector_fus_stage.sv
bench/tb_clock.sv
bench/vector_fus_stage_assert.sv
bench/vector_fus_stage_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f list.f --top-module vector_fus_stage_tb \
  && ./obj_dir/Vvector_fus_stage_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Test OK" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// File: source/ara_defs.svh
// Widths are fixed for one 64-bit element per word, so narrower SEW and other lane counts are not supported
`ifndef ARA_DEFS_SVH
`define ARA_DEFS_SVH

// Width of one vector element
`define ELEN_W 64

// Register file word address width
// Writes wrap modulo 2**VADDR_W
`define VADDR_W 8

// Element count width of one instruction
`define VL_W 8

// Number of instruction ids tracked by the sequencer
`define NR_VINSN 4

// Instruction id width, log2 of NR_VINSN
`define VID_W 2

`endif

// File: source/ara_pkg.sv
// Shared types for the lane execution stage, which needs ara_defs.svh on the include path
`include "ara_defs.svh"

package ara_pkg;

  // One vector element
  typedef logic [`ELEN_W-1:0] elen_t;

  // Byte enables of one element
  typedef logic [`ELEN_W/8-1:0] strb_t;

  // Register file word address
  typedef logic [`VADDR_W-1:0] vaddr_t;

  // Element count of an instruction, never zero
  typedef logic [`VL_W-1:0] vlen_t;

  // Instruction id and its one-hot done form
  typedef logic [`VID_W-1:0] vid_t;
  typedef logic [`NR_VINSN-1:0] vinsn_mask_t;

  // Operations issued by the lane sequencer
  // ALU owns the logic and add/sub group, MFPU owns the multiplies
  typedef enum logic [2:0] {
    VADD  = 3'd0,
    VSUB  = 3'd1,
    VAND  = 3'd2,
    VOR   = 3'd3,
    VXOR  = 3'd4,
    VMUL  = 3'd5,
    VMACC = 3'd6
  } vfu_op_e;

  // Sequencing state shared by both units
  typedef enum logic {
    IDLE = 1'b0,
    BUSY = 1'b1
  } unit_state_e;

endpackage

// File: source/valu.sv
// Integer ALU unit running one instruction at a time and expecting vl of 1 or more
module valu (
  input  logic                 clk_i,
  input  logic                 rst_i,
  // Lane sequencer
  input  ara_pkg::vfu_op_e     vfu_op_i,
  input  ara_pkg::vid_t        vfu_id_i,
  input  ara_pkg::vlen_t       vfu_vl_i,
  input  ara_pkg::vaddr_t      vfu_vd_i,
  input  logic                 vfu_vm_i,
  input  logic                 vfu_operation_valid_i,
  output logic                 alu_ready_o,
  output ara_pkg::vinsn_mask_t alu_vinsn_done_o,
  // Operand queues, port 0 is a and port 1 is b
  input  ara_pkg::elen_t       alu_operand_i [2],
  input  logic                 alu_operand_valid_i [2],
  output logic                 alu_operand_ready_o [2],
  // Register file write port
  output logic                 alu_result_req_o,
  output ara_pkg::vid_t        alu_result_id_o,
  output ara_pkg::vaddr_t      alu_result_addr_o,
  output ara_pkg::elen_t       alu_result_wdata_o,
  output ara_pkg::strb_t       alu_result_be_o,
  input  logic                 alu_result_gnt_i,
  // Shared mask stream
  input  ara_pkg::strb_t       mask_i,
  input  logic                 mask_valid_i,
  output logic                 mask_ready_o
);
  import ara_pkg::*;

  // Control state
  unit_state_e state_q;
  vlen_t       issue_cnt_q;
  vlen_t       gnt_cnt_q;
  logic        res_valid_q;
  vinsn_mask_t done_q;

  // Latched instruction
  vfu_op_e op_q;
  vid_t    id_q;
  vlen_t   vl_q;
  vaddr_t  vd_q;
  logic    vm_q;

  // Result register
  elen_t  res_wdata_q;
  vaddr_t res_addr_q;
  strb_t  res_be_q;

  logic  is_alu_op;
  logic  accept;
  logic  operands_ok;
  logic  step;
  logic  gnt_fire;
  logic  last_gnt;
  elen_t alu_res;

  assign is_alu_op = vfu_op_i inside {VADD, VSUB, VAND, VOR, VXOR};
  assign alu_ready_o = (state_q == IDLE);
  assign accept = vfu_operation_valid_i && is_alu_op && alu_ready_o;

  // Both operands always needed, mask only when masked
  assign operands_ok = alu_operand_valid_i[0] && alu_operand_valid_i[1] &&
                       (vm_q || mask_valid_i);
  // Result slot frees up on grant, so one element per cycle
  assign step = (state_q == BUSY) && (issue_cnt_q != vl_q) && operands_ok &&
                (!res_valid_q || alu_result_gnt_i);

  assign alu_operand_ready_o[0] = step;
  assign alu_operand_ready_o[1] = step;
  assign mask_ready_o = step && !vm_q;

  assign gnt_fire = res_valid_q && alu_result_gnt_i;
  assign last_gnt = gnt_fire && (vlen_t'(gnt_cnt_q + 1'b1) == vl_q);

  // Element datapath
  always_comb begin
    case (op_q)
      VADD:    alu_res = alu_operand_i[0] + alu_operand_i[1];
      VSUB:    alu_res = alu_operand_i[0] - alu_operand_i[1];
      VAND:    alu_res = alu_operand_i[0] & alu_operand_i[1];
      VOR:     alu_res = alu_operand_i[0] | alu_operand_i[1];
      default: alu_res = alu_operand_i[0] ^ alu_operand_i[1];
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= IDLE;
      issue_cnt_q <= '0;
      gnt_cnt_q   <= '0;
      res_valid_q <= 1'b0;
      done_q      <= '0;
    end else begin
      done_q <= '0;
      if (accept) begin
        state_q     <= BUSY;
        issue_cnt_q <= '0;
        gnt_cnt_q   <= '0;
      end
      if (step) begin
        issue_cnt_q <= issue_cnt_q + 1'b1;
        res_valid_q <= 1'b1;
      end else if (gnt_fire) begin
        res_valid_q <= 1'b0;
      end
      if (gnt_fire) begin
        gnt_cnt_q <= gnt_cnt_q + 1'b1;
      end
      // Last write granted, report and free the unit
      if (last_gnt) begin
        state_q <= IDLE;
        done_q  <= vinsn_mask_t'(1) << id_q;
      end
    end
  end

  // Instruction fields, held for the whole instruction
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q <= vfu_op_i;
      id_q <= vfu_id_i;
      vl_q <= vfu_vl_i;
      vd_q <= vfu_vd_i;
      vm_q <= vfu_vm_i;
    end
  end

  // Payload, refilled on each step
  always_ff @(posedge clk_i) begin
    if (step) begin
      res_wdata_q <= alu_res;
      res_addr_q  <= vaddr_t'(vd_q + issue_cnt_q);
      res_be_q    <= vm_q ? '1 : mask_i;
    end
  end

  assign alu_result_req_o   = res_valid_q;
  assign alu_result_id_o    = id_q;
  assign alu_result_addr_o  = res_addr_q;
  assign alu_result_wdata_o = res_wdata_q;
  assign alu_result_be_o    = res_be_q;
  assign alu_vinsn_done_o   = done_q;

endmodule

// File: source/vector_fus_stage.sv
// Lane execution stage where the sequencer must never run masked ops on both units at once
module vector_fus_stage (
  input  logic                 clk_i,
  input  logic                 rst_i,
  // Lane sequencer, broadcast to both units
  input  ara_pkg::vfu_op_e     vfu_op_i,
  input  ara_pkg::vid_t        vfu_id_i,
  input  ara_pkg::vlen_t       vfu_vl_i,
  input  ara_pkg::vaddr_t      vfu_vd_i,
  input  logic                 vfu_vm_i,
  input  logic                 vfu_operation_valid_i,
  output logic                 alu_ready_o,
  output ara_pkg::vinsn_mask_t alu_vinsn_done_o,
  output logic                 mfpu_ready_o,
  output ara_pkg::vinsn_mask_t mfpu_vinsn_done_o,
  // Operand queues
  input  ara_pkg::elen_t       alu_operand_i [2],
  input  logic                 alu_operand_valid_i [2],
  output logic                 alu_operand_ready_o [2],
  input  ara_pkg::elen_t       mfpu_operand_i [3],
  input  logic                 mfpu_operand_valid_i [3],
  output logic                 mfpu_operand_ready_o [3],
  // ALU write port
  output logic                 alu_result_req_o,
  output ara_pkg::vid_t        alu_result_id_o,
  output ara_pkg::vaddr_t      alu_result_addr_o,
  output ara_pkg::elen_t       alu_result_wdata_o,
  output ara_pkg::strb_t       alu_result_be_o,
  input  logic                 alu_result_gnt_i,
  // MFPU write port
  output logic                 mfpu_result_req_o,
  output ara_pkg::vid_t        mfpu_result_id_o,
  output ara_pkg::vaddr_t      mfpu_result_addr_o,
  output ara_pkg::elen_t       mfpu_result_wdata_o,
  output ara_pkg::strb_t       mfpu_result_be_o,
  input  logic                 mfpu_result_gnt_i,
  // Shared mask stream
  input  ara_pkg::strb_t       mask_i,
  input  logic                 mask_valid_i,
  output logic                 mask_ready_o
);
  import ara_pkg::*;

  logic alu_mask_ready;
  logic mfpu_mask_ready;

  // Only one unit consumes masks at a time
  assign mask_ready_o = alu_mask_ready | mfpu_mask_ready;

  // Port names match the units, only mask ready is split
  valu i_valu (
    .mask_ready_o (alu_mask_ready),
    .*
  );

  vmfpu i_vmfpu (
    .mask_ready_o (mfpu_mask_ready),
    .*
  );

endmodule

// File: source/vmfpu.sv
// Integer multiply unit with three elements in flight that stalls whole while a write waits
module vmfpu (
  input  logic                 clk_i,
  input  logic                 rst_i,
  // Lane sequencer
  input  ara_pkg::vfu_op_e     vfu_op_i,
  input  ara_pkg::vid_t        vfu_id_i,
  input  ara_pkg::vlen_t       vfu_vl_i,
  input  ara_pkg::vaddr_t      vfu_vd_i,
  input  logic                 vfu_vm_i,
  input  logic                 vfu_operation_valid_i,
  output logic                 mfpu_ready_o,
  output ara_pkg::vinsn_mask_t mfpu_vinsn_done_o,
  // Operand queues, ports a b c
  input  ara_pkg::elen_t       mfpu_operand_i [3],
  input  logic                 mfpu_operand_valid_i [3],
  output logic                 mfpu_operand_ready_o [3],
  // Register file write port
  output logic                 mfpu_result_req_o,
  output ara_pkg::vid_t        mfpu_result_id_o,
  output ara_pkg::vaddr_t      mfpu_result_addr_o,
  output ara_pkg::elen_t       mfpu_result_wdata_o,
  output ara_pkg::strb_t       mfpu_result_be_o,
  input  logic                 mfpu_result_gnt_i,
  // Shared mask stream
  input  ara_pkg::strb_t       mask_i,
  input  logic                 mask_valid_i,
  output logic                 mask_ready_o
);
  import ara_pkg::*;

  // Control state
  unit_state_e state_q;
  vlen_t       issue_cnt_q;
  vlen_t       gnt_cnt_q;
  vinsn_mask_t done_q;
  // Valid per slot, input register then two pipe stages
  logic        in_valid_q;
  logic        s1_valid_q;
  logic        res_valid_q;

  // Latched instruction
  vfu_op_e op_q;
  vid_t    id_q;
  vlen_t   vl_q;
  vaddr_t  vd_q;
  logic    vm_q;

  // Pipeline payload
  elen_t  in_a_q;
  elen_t  in_b_q;
  elen_t  in_c_q;
  vaddr_t in_addr_q;
  strb_t  in_be_q;
  elen_t  s1_prod_q;
  elen_t  s1_c_q;
  vaddr_t s1_addr_q;
  strb_t  s1_be_q;
  elen_t  res_wdata_q;
  vaddr_t res_addr_q;
  strb_t  res_be_q;

  logic is_mfpu_op;
  logic is_macc;
  logic accept;
  logic advance;
  logic operands_ok;
  logic step;
  logic gnt_fire;
  logic last_gnt;

  assign is_mfpu_op = vfu_op_i inside {VMUL, VMACC};
  assign is_macc = (op_q == VMACC);
  assign mfpu_ready_o = (state_q == IDLE);
  assign accept = vfu_operation_valid_i && is_mfpu_op && mfpu_ready_o;

  // Whole pipe holds while the result is requested and not granted
  assign advance = !res_valid_q || mfpu_result_gnt_i;
  // Port c only matters for VMACC
  assign operands_ok = mfpu_operand_valid_i[0] && mfpu_operand_valid_i[1] &&
                       (!is_macc || mfpu_operand_valid_i[2]) &&
                       (vm_q || mask_valid_i);
  assign step = (state_q == BUSY) && (issue_cnt_q != vl_q) && operands_ok && advance;

  assign mfpu_operand_ready_o[0] = step;
  assign mfpu_operand_ready_o[1] = step;
  assign mfpu_operand_ready_o[2] = step && is_macc;
  assign mask_ready_o = step && !vm_q;

  assign gnt_fire = res_valid_q && mfpu_result_gnt_i;
  assign last_gnt = gnt_fire && (vlen_t'(gnt_cnt_q + 1'b1) == vl_q);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= IDLE;
      issue_cnt_q <= '0;
      gnt_cnt_q   <= '0;
      done_q      <= '0;
      in_valid_q  <= 1'b0;
      s1_valid_q  <= 1'b0;
      res_valid_q <= 1'b0;
    end else begin
      done_q <= '0;
      if (accept) begin
        state_q     <= BUSY;
        issue_cnt_q <= '0;
        gnt_cnt_q   <= '0;
      end
      if (step) begin
        issue_cnt_q <= issue_cnt_q + 1'b1;
      end
      // Valid bits shift together, bubbles included
      if (advance) begin
        in_valid_q  <= step;
        s1_valid_q  <= in_valid_q;
        res_valid_q <= s1_valid_q;
      end
      if (gnt_fire) begin
        gnt_cnt_q <= gnt_cnt_q + 1'b1;
      end
      if (last_gnt) begin
        state_q <= IDLE;
        done_q  <= vinsn_mask_t'(1) << id_q;
      end
    end
  end

  // Instruction fields
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q <= vfu_op_i;
      id_q <= vfu_id_i;
      vl_q <= vfu_vl_i;
      vd_q <= vfu_vd_i;
      vm_q <= vfu_vm_i;
    end
  end

  // Operand capture
  always_ff @(posedge clk_i) begin
    if (step) begin
      in_a_q    <= mfpu_operand_i[0];
      in_b_q    <= mfpu_operand_i[1];
      in_c_q    <= mfpu_operand_i[2];
      in_addr_q <= vaddr_t'(vd_q + issue_cnt_q);
      in_be_q   <= vm_q ? '1 : mask_i;
    end
  end

  // Stage one, low 64 bits of the product
  always_ff @(posedge clk_i) begin
    if (advance && in_valid_q) begin
      s1_prod_q <= in_a_q * in_b_q;
      s1_c_q    <= in_c_q;
      s1_addr_q <= in_addr_q;
      s1_be_q   <= in_be_q;
    end
  end

  // Stage two, accumulate c for VMACC only
  always_ff @(posedge clk_i) begin
    if (advance && s1_valid_q) begin
      res_wdata_q <= s1_prod_q + (is_macc ? s1_c_q : '0);
      res_addr_q  <= s1_addr_q;
      res_be_q    <= s1_be_q;
    end
  end

  assign mfpu_result_req_o   = res_valid_q;
  assign mfpu_result_id_o    = id_q;
  assign mfpu_result_addr_o  = res_addr_q;
  assign mfpu_result_wdata_o = res_wdata_q;
  assign mfpu_result_be_o    = res_be_q;
  assign mfpu_vinsn_done_o   = done_q;

endmodule
